/* hw/xr_consts.svh */
`ifndef XR_CONSTS_SVH
`define XR_CONSTS_SVH

// bus widths
`define XR_WORD_W       16
`define XR_ADDR_W       16

// memory index widths, tile bit 10 picks the second part
`define XR_COLOR_W      8
`define XR_TILE_W       11
`define XR_TILE2_W      9
`define XR_REG_W        3

// region codes in address bits 15:14
`define XR_RGN_REG      2'd0
`define XR_RGN_TILE     2'd1
`define XR_RGN_COLOR    2'd2
`define XR_RGN_RSVD     2'd3

`define XR_ID_VALUE     16'hA57E

`endif

/* hw/xr_types_pkg.sv */
`default_nettype none

`include "xr_consts.svh"

package xr_types_pkg;

    // one data word on any XR port
    typedef logic [`XR_WORD_W-1:0] word_t;

    // full XR address, region in the top two bits
    typedef logic [`XR_ADDR_W-1:0] addr_t;

    // color table entry as stored in the lookup RAMs
    typedef logic [`XR_WORD_W-1:0] argb_t;

endpackage

`default_nettype wire

/* hw/xr_map_pkg.sv */
`default_nettype none

`include "xr_consts.svh"

package xr_map_pkg;

    // region field, address bits 15:14
    typedef enum logic [1:0] {
        REG_REGION   = `XR_RGN_REG,
        TILE_REGION  = `XR_RGN_TILE,
        COLOR_REGION = `XR_RGN_COLOR,
        RSVD_REGION  = `XR_RGN_RSVD
    } xr_region_t;

    // entry index within one color bank
    typedef logic [`XR_COLOR_W-1:0] color_addr_t;

    // tile word address across both tile parts
    typedef logic [`XR_TILE_W-1:0] tile_addr_t;

    // configuration register index
    typedef logic [`XR_REG_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

/* hw/xr_ifs.sv */
`default_nettype none
`timescale 1ns/100ps

// register bank port, rdata shows the register addressed last cycle
interface xr_reg_bus_if;
    import xr_types_pkg::*;
    import xr_map_pkg::*;

    logic     wr;
    reg_idx_t addr;
    word_t    wdata;
    word_t    rdata;

    modport arb (
        output wr,
        output addr,
        output wdata,
        input  rdata
    );

    modport regs (
        input  wr,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

// one read port and one write port of a block RAM
interface xr_ram_if #(
    parameter int AWIDTH = 8
);
    import xr_types_pkg::*;

    logic              rd_en;
    logic [AWIDTH-1:0] rd_addr;
    word_t             rd_data;
    logic              wr_en;
    logic [AWIDTH-1:0] wr_addr;
    word_t             wr_data;

    modport ctrl (
        output rd_en,
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport ram (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );
endinterface

`default_nettype wire

/* hw/xr_dpram.sv */
`default_nettype none
`timescale 1ns/100ps

module xr_dpram #(
    parameter int AWIDTH = 8
) (
    input  wire logic clk,
    xr_ram_if.ram     mem
);
    import xr_types_pkg::*;

    localparam int DEPTH = 2 ** AWIDTH;

    word_t ram_q [DEPTH];

    // write port, lands at the clock edge
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    // read port, output holds until the next read
    // a read of the word being written returns the old contents
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram_q[mem.rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/xr_config_regs.sv */
`default_nettype none
`timescale 1ns/100ps

`include "xr_consts.svh"

module xr_config_regs (
    input  wire logic   clk,
    input  wire logic   rst_n_i,
    xr_reg_bus_if.regs  bus
);
    import xr_types_pkg::*;
    import xr_map_pkg::*;

    localparam int NUM_REGS = 2 ** `XR_REG_W;

    // register 0 is the fixed ID, only 1..7 need storage
    word_t regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (bus.wr && bus.addr != reg_idx_t'(0)) begin
            regs_q[bus.addr] <= bus.wdata;
        end
    end

    // read data follows the address one cycle later
    always_ff @(posedge clk) begin
        if (bus.addr == reg_idx_t'(0)) begin
            bus.rdata <= word_t'(`XR_ID_VALUE);
        end else begin
            bus.rdata <= regs_q[bus.addr];
        end
    end

endmodule

`default_nettype wire

/* hw/xr_mem_arb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "xr_consts.svh"

module xr_mem_arb #(
    parameter int EN_COLOR_B = 1
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    // host port, read and write
    input  wire logic                     host_sel_i,
    input  wire logic                     host_wr_i,
    input  wire xr_types_pkg::addr_t      host_addr_i,
    input  wire xr_types_pkg::word_t      host_data_i,
    output      logic                     host_ack_o,
    output      xr_types_pkg::word_t      host_data_o,
    // copper port, write only
    input  wire logic                     cop_sel_i,
    input  wire xr_types_pkg::addr_t      cop_addr_i,
    input  wire xr_types_pkg::word_t      cop_data_i,
    output      logic                     cop_ack_o,
    // video color lookup, both banks read together
    input  wire logic                     vid_color_sel_i,
    input  wire xr_map_pkg::color_addr_t  vid_color_a_addr_i,
    input  wire xr_map_pkg::color_addr_t  vid_color_b_addr_i,
    output      xr_types_pkg::argb_t      vid_color_a_data_o,
    output      xr_types_pkg::argb_t      vid_color_b_data_o,
    // video tile fetch
    input  wire logic                     vid_tile_sel_i,
    input  wire xr_map_pkg::tile_addr_t   vid_tile_addr_i,
    output      xr_types_pkg::word_t      vid_tile_data_o,
    xr_reg_bus_if.arb                     regs
);
    import xr_types_pkg::*;
    import xr_map_pkg::*;

    xr_ram_if #(.AWIDTH(`XR_TILE_W-1)) tile_ram ();
    xr_ram_if #(.AWIDTH(`XR_TILE2_W))  tile2_ram ();
    xr_ram_if #(.AWIDTH(`XR_COLOR_W))  color_a_ram ();
    xr_ram_if #(.AWIDTH(`XR_COLOR_W))  color_b_ram ();

    xr_region_t host_rgn;
    xr_region_t wr_rgn;
    addr_t      wr_addr;
    word_t      wr_data;
    logic       cop_acc;
    logic       host_req;
    logic       host_rd_free;
    logic       host_wr_acc;
    logic       host_rd_acc;
    logic       wr_acc;
    logic       tile_rd_en;
    tile_addr_t tile_rd_addr;
    logic       tile_part_q;
    word_t      tile_data;
    argb_t      color_b_data;

    assign host_rgn = xr_region_t'(host_addr_i[15:14]);

    // copper owns the write path whenever it asks
    assign wr_addr = cop_sel_i ? cop_addr_i : host_addr_i;
    assign wr_data = cop_sel_i ? cop_data_i : host_data_i;
    assign wr_rgn  = xr_region_t'(wr_addr[15:14]);

    // host reads wait for video to leave the target RAM
    always_comb begin
        case (host_rgn)
            TILE_REGION:  host_rd_free = ~vid_tile_sel_i;
            COLOR_REGION: host_rd_free = ~vid_color_sel_i;
            default:      host_rd_free = 1'b1;
        endcase
    end

    assign cop_acc     = cop_sel_i & ~cop_ack_o;
    assign host_req    = host_sel_i & ~host_ack_o & ~cop_sel_i;
    assign host_wr_acc = host_req & host_wr_i;
    assign host_rd_acc = host_req & ~host_wr_i & host_rd_free;
    assign wr_acc      = cop_acc | host_wr_acc;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cop_ack_o  <= 1'b0;
            host_ack_o <= 1'b0;
        end else begin
            cop_ack_o  <= cop_acc;
            host_ack_o <= host_wr_acc | host_rd_acc;
        end
    end

    // register bank, host reads use the same address lines
    assign regs.wr    = wr_acc & (wr_rgn == REG_REGION);
    assign regs.addr  = wr_addr[`XR_REG_W-1:0];
    assign regs.wdata = wr_data;

    // tile read port, video first
    always_comb begin
        tile_rd_en   = 1'b0;
        tile_rd_addr = vid_tile_addr_i;
        if (vid_tile_sel_i) begin
            tile_rd_en = 1'b1;
        end else if (host_rd_acc && host_rgn == TILE_REGION) begin
            tile_rd_en   = 1'b1;
            tile_rd_addr = host_addr_i[`XR_TILE_W-1:0];
        end
    end

    // remember which tile part was read for output steering
    always_ff @(posedge clk) begin
        if (tile_rd_en) begin
            tile_part_q <= tile_rd_addr[`XR_TILE_W-1];
        end
    end

    assign tile_ram.rd_en    = tile_rd_en & ~tile_rd_addr[`XR_TILE_W-1];
    assign tile_ram.rd_addr  = tile_rd_addr[`XR_TILE_W-2:0];
    assign tile_ram.wr_en    = wr_acc & (wr_rgn == TILE_REGION) & ~wr_addr[`XR_TILE_W-1];
    assign tile_ram.wr_addr  = wr_addr[`XR_TILE_W-2:0];
    assign tile_ram.wr_data  = wr_data;

    assign tile2_ram.rd_en   = tile_rd_en & tile_rd_addr[`XR_TILE_W-1];
    assign tile2_ram.rd_addr = tile_rd_addr[`XR_TILE2_W-1:0];
    assign tile2_ram.wr_en   = wr_acc & (wr_rgn == TILE_REGION) & wr_addr[`XR_TILE_W-1];
    assign tile2_ram.wr_addr = wr_addr[`XR_TILE2_W-1:0];
    assign tile2_ram.wr_data = wr_data;

    // color read port, both banks share enable, bit 8 picks the bank
    assign color_a_ram.rd_en   = vid_color_sel_i | (host_rd_acc & (host_rgn == COLOR_REGION));
    assign color_a_ram.rd_addr = vid_color_sel_i ? vid_color_a_addr_i
                                                 : host_addr_i[`XR_COLOR_W-1:0];
    assign color_a_ram.wr_en   = wr_acc & (wr_rgn == COLOR_REGION) & ~wr_addr[`XR_COLOR_W];
    assign color_a_ram.wr_addr = wr_addr[`XR_COLOR_W-1:0];
    assign color_a_ram.wr_data = wr_data;

    assign color_b_ram.rd_en   = color_a_ram.rd_en;
    assign color_b_ram.rd_addr = vid_color_sel_i ? vid_color_b_addr_i
                                                 : host_addr_i[`XR_COLOR_W-1:0];
    assign color_b_ram.wr_en   = wr_acc & (wr_rgn == COLOR_REGION) & wr_addr[`XR_COLOR_W];
    assign color_b_ram.wr_addr = wr_addr[`XR_COLOR_W-1:0];
    assign color_b_ram.wr_data = wr_data;

    xr_dpram #(.AWIDTH(`XR_TILE_W-1)) u_tile_ram (.clk(clk), .mem(tile_ram.ram));
    xr_dpram #(.AWIDTH(`XR_TILE2_W))  u_tile2_ram (.clk(clk), .mem(tile2_ram.ram));
    xr_dpram #(.AWIDTH(`XR_COLOR_W))  u_color_a_ram (.clk(clk), .mem(color_a_ram.ram));

    generate
        if (EN_COLOR_B != 0) begin : g_color_b
            xr_dpram #(.AWIDTH(`XR_COLOR_W)) u_color_b_ram (.clk(clk), .mem(color_b_ram.ram));
            assign color_b_data = color_b_ram.rd_data;
        end else begin : g_no_color_b
            // bank B absent, writes vanish and reads give zero
            assign color_b_data = '0;
        end
    endgenerate

    assign tile_data          = tile_part_q ? tile2_ram.rd_data : tile_ram.rd_data;
    assign vid_tile_data_o    = tile_data;
    assign vid_color_a_data_o = color_a_ram.rd_data;
    assign vid_color_b_data_o = color_b_data;

    // host read result, picked by the address still held in the ack cycle
    always_comb begin
        case (host_rgn)
            REG_REGION:   host_data_o = regs.rdata;
            TILE_REGION:  host_data_o = tile_data;
            COLOR_REGION: host_data_o = host_addr_i[`XR_COLOR_W] ? color_b_data
                                                                 : color_a_ram.rd_data;
            default:      host_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/xr_subsys_top.sv */
`default_nettype none
`timescale 1ns/100ps

module xr_subsys_top #(
    parameter int EN_COLOR_B = 1
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n_i,
    // host port
    input  wire logic                     host_sel_i,
    input  wire logic                     host_wr_i,
    input  wire xr_types_pkg::addr_t      host_addr_i,
    input  wire xr_types_pkg::word_t      host_data_i,
    output      logic                     host_ack_o,
    output      xr_types_pkg::word_t      host_data_o,
    // copper port
    input  wire logic                     cop_sel_i,
    input  wire xr_types_pkg::addr_t      cop_addr_i,
    input  wire xr_types_pkg::word_t      cop_data_i,
    output      logic                     cop_ack_o,
    // video ports
    input  wire logic                     vid_color_sel_i,
    input  wire xr_map_pkg::color_addr_t  vid_color_a_addr_i,
    input  wire xr_map_pkg::color_addr_t  vid_color_b_addr_i,
    output      xr_types_pkg::argb_t      vid_color_a_data_o,
    output      xr_types_pkg::argb_t      vid_color_b_data_o,
    input  wire logic                     vid_tile_sel_i,
    input  wire xr_map_pkg::tile_addr_t   vid_tile_addr_i,
    output      xr_types_pkg::word_t      vid_tile_data_o
);

    xr_reg_bus_if reg_bus ();

    xr_mem_arb #(
        .EN_COLOR_B(EN_COLOR_B)
    ) u_mem_arb (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .host_sel_i         (host_sel_i),
        .host_wr_i          (host_wr_i),
        .host_addr_i        (host_addr_i),
        .host_data_i        (host_data_i),
        .host_ack_o         (host_ack_o),
        .host_data_o        (host_data_o),
        .cop_sel_i          (cop_sel_i),
        .cop_addr_i         (cop_addr_i),
        .cop_data_i         (cop_data_i),
        .cop_ack_o          (cop_ack_o),
        .vid_color_sel_i    (vid_color_sel_i),
        .vid_color_a_addr_i (vid_color_a_addr_i),
        .vid_color_b_addr_i (vid_color_b_addr_i),
        .vid_color_a_data_o (vid_color_a_data_o),
        .vid_color_b_data_o (vid_color_b_data_o),
        .vid_tile_sel_i     (vid_tile_sel_i),
        .vid_tile_addr_i    (vid_tile_addr_i),
        .vid_tile_data_o    (vid_tile_data_o),
        .regs               (reg_bus.arb)
    );

    xr_config_regs u_config_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (reg_bus.regs)
    );

endmodule

`default_nettype wire

/* testbench/xr_subsys_props.sv */
`default_nettype none
`timescale 1ns/100ps

module xr_subsys_props (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic host_sel_i,
    input wire logic host_ack_o,
    input wire logic cop_sel_i,
    input wire logic cop_ack_o
);
    // failed checks so far, watched by the testbench
    int unsigned fail_count = 0;

    // acks are single-cycle pulses
    a_host_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_ack_o |=> !host_ack_o)
        else begin
            fail_count++;
            $error("host_ack_o high for two cycles in a row");
        end

    a_cop_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        cop_ack_o |=> !cop_ack_o)
        else begin
            fail_count++;
            $error("cop_ack_o high for two cycles in a row");
        end

    // every ack answers a request seen the cycle before
    a_host_ack_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_ack_o |-> $past(host_sel_i))
        else begin
            fail_count++;
            $error("host_ack_o without host_sel_i in the previous cycle");
        end

    a_cop_ack_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        cop_ack_o |-> $past(cop_sel_i))
        else begin
            fail_count++;
            $error("cop_ack_o without cop_sel_i in the previous cycle");
        end

    a_ack_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(host_ack_o && cop_ack_o))
        else begin
            fail_count++;
            $error("host_ack_o and cop_ack_o high together");
        end

    // copper holds off the host
    a_cop_first: assert property (@(posedge clk) disable iff (!rst_n_i)
        host_ack_o |-> !$past(cop_sel_i))
        else begin
            fail_count++;
            $error("host_ack_o after a cycle with cop_sel_i high");
        end

endmodule

bind xr_mem_arb xr_subsys_props u_props (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .host_sel_i (host_sel_i),
    .host_ack_o (host_ack_o),
    .cop_sel_i  (cop_sel_i),
    .cop_ack_o  (cop_ack_o)
);

`default_nettype wire

/* testbench/xr_subsys_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "xr_consts.svh"

module xr_subsys_tb;
    import xr_types_pkg::*;
    import xr_map_pkg::*;

    localparam int N_TILE     = 300;
    localparam int N_COLOR_WR = 64;
    localparam int N_VID      = 64;
    localparam int N_COLOR_RD = 32;
    localparam int N_REG      = 16;
    localparam int N_PAIR     = 40;
    localparam int N_CONT     = 60;
    localparam int N_RSVD     = 8;
    localparam int TOTAL_TXN  = 2 * N_TILE + N_COLOR_WR + N_VID + N_COLOR_RD + N_REG + 8
                              + 2 * N_PAIR + N_CONT + 3 * N_RSVD;
    localparam longint TIMEOUT_NS = longint'(TOTAL_TXN) * 64 * 8;

    logic        clk;
    logic        rst_n_i;
    logic        host_sel_i;
    logic        host_wr_i;
    addr_t       host_addr_i;
    word_t       host_data_i;
    logic        host_ack_o;
    word_t       host_data_o;
    logic        cop_sel_i;
    addr_t       cop_addr_i;
    word_t       cop_data_i;
    logic        cop_ack_o;
    logic        vid_color_sel_i;
    color_addr_t vid_color_a_addr_i;
    color_addr_t vid_color_b_addr_i;
    argb_t       vid_color_a_data_o;
    argb_t       vid_color_b_data_o;
    logic        vid_tile_sel_i;
    tile_addr_t  vid_tile_addr_i;
    word_t       vid_tile_data_o;

    integer seed = 62383;

    // reference model of all storage
    word_t tile_m [1024];
    word_t tile2_m [512];
    argb_t color_a_m [256];
    argb_t color_b_m [256];
    word_t reg_m [8];

    tile_addr_t  tile_q[$];
    color_addr_t color_a_q[$];
    color_addr_t color_b_q[$];
    addr_t       addr_q[$];

    logic  vid_color_pend = 1'b0;
    logic  vid_tile_pend = 1'b0;
    argb_t exp_color_a;
    argb_t exp_color_b;
    word_t exp_tile;
    logic  host_busy;

    xr_subsys_top DUT (.*);

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input word_t actual, input word_t expected, input string msg);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
            abort_run();
        end
    endtask

    function automatic int unsigned rnd(input int unsigned n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t tile_read(input tile_addr_t a);
        tile_read = a[10] ? tile2_m[a[8:0]] : tile_m[a[9:0]];
    endfunction

    function automatic void model_write(input addr_t a, input word_t d);
        case (xr_region_t'(a[15:14]))
            REG_REGION: begin
                if (a[2:0] != 3'd0) begin
                    reg_m[a[2:0]] = d;
                end
            end
            TILE_REGION: begin
                if (a[10]) begin
                    tile2_m[a[8:0]] = d;
                end else begin
                    tile_m[a[9:0]] = d;
                end
            end
            COLOR_REGION: begin
                if (a[8]) begin
                    color_b_m[a[7:0]] = d;
                end else begin
                    color_a_m[a[7:0]] = d;
                end
            end
            default: ;
        endcase
    endfunction

    function automatic word_t model_read(input addr_t a);
        case (xr_region_t'(a[15:14]))
            REG_REGION:   model_read = (a[2:0] == 3'd0) ? word_t'(`XR_ID_VALUE) : reg_m[a[2:0]];
            TILE_REGION:  model_read = tile_read(a[10:0]);
            COLOR_REGION: model_read = a[8] ? color_b_m[a[7:0]] : color_a_m[a[7:0]];
            default:      model_read = '0;
        endcase
    endfunction

    // kind 0 register, 1 tile, 2 color, 3 reserved
    // tile and color picks only hit words already written
    function automatic addr_t pick_addr(input int unsigned kind);
        case (kind)
            0: pick_addr = {REG_REGION, 11'd0, reg_idx_t'(rnd(8))};
            1: pick_addr = {TILE_REGION, 3'd0, tile_q[rnd(tile_q.size())]};
            2: begin
                if (rnd(2) == 0) begin
                    pick_addr = {COLOR_REGION, 6'd0, color_a_q[rnd(color_a_q.size())]};
                end else begin
                    pick_addr = {COLOR_REGION, 6'd1, color_b_q[rnd(color_b_q.size())]};
                end
            end
            default: pick_addr = {RSVD_REGION, 14'(rnd(16384))};
        endcase
    endfunction

    task automatic host_access(input logic wr, input addr_t addr, input word_t data);
        host_sel_i  <= 1'b1;
        host_wr_i   <= wr;
        host_addr_i <= addr;
        host_data_i <= data;
        do @(posedge clk); while (!host_ack_o);
        host_sel_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic cop_write(input addr_t addr, input word_t data);
        cop_sel_i  <= 1'b1;
        cop_addr_i <= addr;
        cop_data_i <= data;
        do @(posedge clk); while (!cop_ack_o);
        cop_sel_i <= 1'b0;
        @(posedge clk);
    endtask

    // samples the cycle that just ended
    // the model follows the ack order
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (DUT.u_mem_arb.u_props.fail_count != 0) begin
                $display("acknowledge assertion failed at %0t ns", $time);
                abort_run();
            end
            if (vid_color_pend) begin
                check_eq(vid_color_a_data_o, exp_color_a, "video color A");
                check_eq(vid_color_b_data_o, exp_color_b, "video color B");
            end
            if (vid_tile_pend) begin
                check_eq(vid_tile_data_o, exp_tile, "video tile");
            end
            if (cop_ack_o) begin
                model_write(cop_addr_i, cop_data_i);
            end
            if (host_ack_o && host_wr_i) begin
                model_write(host_addr_i, host_data_i);
            end else if (host_ack_o) begin
                check_eq(host_data_o, model_read(host_addr_i), "host read");
            end
            vid_color_pend = vid_color_sel_i;
            exp_color_a    = color_a_m[vid_color_a_addr_i];
            exp_color_b    = color_b_m[vid_color_b_addr_i];
            vid_tile_pend  = vid_tile_sel_i;
            exp_tile       = tile_read(vid_tile_addr_i);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: handshake never completed");
        abort_run();
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        host_sel_i = 1'b0;
        host_wr_i = 1'b0;
        host_addr_i = '0;
        host_data_i = '0;
        cop_sel_i = 1'b0;
        cop_addr_i = '0;
        cop_data_i = '0;
        vid_color_sel_i = 1'b0;
        vid_color_a_addr_i = '0;
        vid_color_b_addr_i = '0;
        vid_tile_sel_i = 1'b0;
        vid_tile_addr_i = '0;
        foreach (reg_m[i]) begin
            reg_m[i] = '0;
        end
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);

        // tile writes across both parts then read back
        repeat (N_TILE) begin
            tile_q.push_back(tile_addr_t'(rnd(2048)));
            host_access(1'b1, {TILE_REGION, 3'd0, tile_q[$]}, word_t'($random(seed)));
        end
        foreach (tile_q[i]) begin
            host_access(1'b0, {TILE_REGION, 3'd0, tile_q[i]}, '0);
        end

        // color banks, video lookups, host reads
        for (int i = 0; i < N_COLOR_WR; i++) begin
            if (i % 2 == 0) begin
                color_a_q.push_back(color_addr_t'(rnd(256)));
                host_access(1'b1, {COLOR_REGION, 6'd0, color_a_q[$]}, word_t'($random(seed)));
            end else begin
                color_b_q.push_back(color_addr_t'(rnd(256)));
                host_access(1'b1, {COLOR_REGION, 6'd1, color_b_q[$]}, word_t'($random(seed)));
            end
        end
        repeat (N_VID) begin
            vid_color_sel_i    <= 1'b1;
            vid_color_a_addr_i <= color_a_q[rnd(color_a_q.size())];
            vid_color_b_addr_i <= color_b_q[rnd(color_b_q.size())];
            @(posedge clk);
        end
        vid_color_sel_i <= 1'b0;
        @(posedge clk);
        repeat (N_COLOR_RD) begin
            host_access(1'b0, pick_addr(2), '0);
        end

        // register bank where register 0 keeps the ID
        repeat (N_REG) begin
            host_access(1'b1, pick_addr(0), word_t'($random(seed)));
        end
        for (int i = 0; i < 8; i++) begin
            host_access(1'b0, {REG_REGION, 11'd0, reg_idx_t'(i)}, '0);
        end

        // copper and host together and sometimes on the same address
        repeat (N_PAIR) begin
            addr_q.push_back(pick_addr(rnd(4)));
            addr_q.push_back((rnd(4) == 0) ? addr_q[$] : pick_addr(rnd(4)));
            fork
                cop_write(addr_q[$-1], word_t'($random(seed)));
                host_access(logic'(rnd(2)), addr_q[$], word_t'($random(seed)));
            join
        end

        // host reads while video toggles on both RAMs
        addr_q.delete();
        repeat (N_CONT) begin
            addr_q.push_back(pick_addr(1 + rnd(2)));
        end
        host_busy = 1'b1;
        fork
            begin
                foreach (addr_q[i]) begin
                    host_access(1'b0, addr_q[i], '0);
                end
                host_busy <= 1'b0;
            end
            begin
                while (host_busy) begin
                    vid_tile_sel_i     <= logic'(rnd(2));
                    vid_tile_addr_i    <= tile_q[rnd(tile_q.size())];
                    vid_color_sel_i    <= logic'(rnd(2));
                    vid_color_a_addr_i <= color_a_q[rnd(color_a_q.size())];
                    vid_color_b_addr_i <= color_b_q[rnd(color_b_q.size())];
                    @(posedge clk);
                end
                vid_tile_sel_i  <= 1'b0;
                vid_color_sel_i <= 1'b0;
                @(posedge clk);
            end
        join

        // reserved writes share their low bits with live words
        addr_q.delete();
        repeat (N_RSVD) begin
            addr_q.push_back(pick_addr(rnd(3)));
            host_access(1'b1, {RSVD_REGION, addr_q[$][13:0]}, word_t'($random(seed)));
        end
        repeat (N_RSVD) begin
            host_access(1'b0, pick_addr(3), '0);
        end
        // those live words must be untouched
        foreach (addr_q[i]) begin
            host_access(1'b0, addr_q[i], '0);
        end

        repeat (4) @(posedge clk);
        if (DUT.u_mem_arb.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("acknowledge assertions failed");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+hw
hw/xr_types_pkg.sv
hw/xr_map_pkg.sv
hw/xr_ifs.sv
hw/xr_dpram.sv
hw/xr_config_regs.sv
hw/xr_mem_arb.sv
hw/xr_subsys_top.sv
testbench/xr_subsys_props.sv
testbench/xr_subsys_tb.sv
